/* common/fft_depkt_pkg.sv */
// FFT depacketizer definitions
`default_nettype none

package fft_depkt_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------

  // One complex sample and its footprint on the NoC
  localparam int ITEM_W         = 32;
  localparam int BYTES_PER_ITEM = 4;

  // Largest packet and largest FFT, in items, given as log2
  localparam int MAX_PKT_SIZE_LOG2 = 8;
  localparam int MAX_FFT_SIZE_LOG2 = 6;

  // FIFO depths as log2 of the entry count
  localparam int SYMB_FIFO_DEPTH_LOG2 = 4;
  localparam int CP_FIFO_DEPTH_LOG2   = 4;
  localparam int DATA_FIFO_DEPTH_LOG2 = 6;

  // ----------------------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------------------

  typedef logic [ITEM_W-1:0]                      item_t;
  typedef logic [MAX_PKT_SIZE_LOG2:0]             pkt_size_t;
  // Wide enough for the largest FFT plus the largest prefix
  typedef logic [MAX_FFT_SIZE_LOG2+1:0]           fft_size_t;
  typedef logic [$clog2(MAX_FFT_SIZE_LOG2+1)-1:0] fft_log2_t;
  typedef logic [MAX_FFT_SIZE_LOG2-1:0]           cp_len_t;
  typedef logic [63:0]                            timestamp_t;
  typedef logic [15:0]                            length_bytes_t;
  // Holds just under one packet plus one full symbol with prefix
  typedef logic [MAX_PKT_SIZE_LOG2+1:0]           items_left_t;

  // ----------------------------------------------------------------------
  // Sideband structs
  // ----------------------------------------------------------------------

  // Per-burst settings from the packetizer
  typedef struct packed {
    pkt_size_t  pkt_size;
    timestamp_t timestamp;
    logic       has_time;
  } burst_info_t;

  // One entry per symbol, passed from the sizer to the resizer
  typedef struct packed {
    logic      last;
    fft_size_t length;
  } symbol_len_t;

  // Header fields that go with each outgoing NoC packet
  typedef struct packed {
    length_bytes_t length;
    timestamp_t    timestamp;
    logic          has_time;
    logic          eov;
    logic          eob;
  } noc_side_t;

endpackage

`default_nettype wire

/* src/sync_fifo.sv */
// Synchronous FWFT FIFO
`default_nettype none

module sync_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_LOG2 = 4
) (
  input  wire              clk,
  input  wire              rst,
  input  wire  [WIDTH-1:0] i_wdata,
  input  wire              i_wvalid,
  output logic             o_wready,
  output logic [WIDTH-1:0] o_rdata,
  output logic             o_rvalid,
  input  wire              i_rready
);

  // Storage has no reset, only the pointers and count do
  logic [WIDTH-1:0]      mem [2**DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  // One extra bit so that full and empty can be told apart
  logic [DEPTH_LOG2:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = i_wvalid && o_wready;
  assign do_rd = o_rvalid && i_rready;

  // The top bit of the count is set only when every entry is in use
  assign o_wready = !count[DEPTH_LOG2];
  assign o_rvalid = (count != '0);
  // Head entry is shown directly, so a write appears one cycle later
  assign o_rdata  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous read and write leave the count unchanged
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* symbol_sizer/symbol_sizer.sv */
// Symbol length and prefix FSM
`default_nettype none

module symbol_sizer (
  input  wire                        clk,
  input  wire                        rst,
  input  wire fft_depkt_pkg::fft_log2_t i_fft_size_log2,
  // Symbol notice from the packetizer
  input  wire                        i_symbol_tvalid,
  input  wire                        i_symbol_last,
  output logic                       o_symbol_tready,
  // Current prefix length, read once per notice
  input  wire fft_depkt_pkg::cp_len_t i_cp_ins_tdata,
  input  wire                        i_cp_ins_tvalid,
  output logic                       o_cp_ins_rd,
  // Prefix copy toward the insertion logic
  output fft_depkt_pkg::cp_len_t     o_cp_ins_tdata,
  output logic                       o_cp_ins_tvalid,
  input  wire                        i_cp_ins_tready_dn,
  // Symbol lengths toward the packet resizer
  output fft_depkt_pkg::symbol_len_t o_len_tdata,
  output logic                       o_len_tvalid,
  input  wire                        i_len_tready
);

  typedef enum logic [1:0] {
    WAIT_ST,
    CALC_ST,
    PASS_ST
  } state_t;

  state_t                    state;
  fft_depkt_pkg::fft_size_t  fft_size;
  fft_depkt_pkg::cp_len_t    cp_len;
  fft_depkt_pkg::symbol_len_t len_wdata;
  logic                      len_wvalid;
  logic                      len_wready;
  logic                      prefix_rd_stb;
  logic                      cp_wready;

  // FFT size in items, expanded from its log2
  always_ff @(posedge clk) begin
    fft_size <= fft_depkt_pkg::fft_size_t'(1) << i_fft_size_log2;
  end

  // ----------------------------------------------------------------------
  // Notice handling
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= WAIT_ST;
      o_symbol_tready <= 1'b0;
      prefix_rd_stb   <= 1'b0;
      len_wvalid      <= 1'b0;
    end else begin
      o_symbol_tready <= 1'b0;
      prefix_rd_stb   <= 1'b0;
      case (state)
        WAIT_ST: begin
          // Only offer to take a notice while both FIFOs can take an entry
          o_symbol_tready <= len_wready && cp_wready && i_cp_ins_tvalid;
          if (i_symbol_tvalid && o_symbol_tready) begin
            o_symbol_tready <= 1'b0;
            prefix_rd_stb   <= 1'b1;
            state           <= CALC_ST;
          end
        end
        CALC_ST: begin
          // Prefix read strobe is high during this cycle
          len_wvalid <= 1'b1;
          state      <= PASS_ST;
        end
        PASS_ST: begin
          // Hold the length until the symbol FIFO takes it
          if (len_wready) begin
            len_wvalid <= 1'b0;
            state      <= WAIT_ST;
          end
        end
        default: begin
          state <= WAIT_ST;
        end
      endcase
    end
  end

  // Payload captured along with the handshake
  always_ff @(posedge clk) begin
    if (state == WAIT_ST && i_symbol_tvalid && o_symbol_tready) begin
      len_wdata.last <= i_symbol_last;
      cp_len         <= i_cp_ins_tdata;
    end
    if (state == CALC_ST) begin
      len_wdata.length <= fft_size + fft_depkt_pkg::fft_size_t'(cp_len);
    end
  end

  assign o_cp_ins_rd = prefix_rd_stb;

  // ----------------------------------------------------------------------
  // FIFOs
  // ----------------------------------------------------------------------

  sync_fifo #(
    .WIDTH      ($bits(fft_depkt_pkg::symbol_len_t)),
    .DEPTH_LOG2 (fft_depkt_pkg::SYMB_FIFO_DEPTH_LOG2)
  ) u_len_fifo (
    .clk      (clk),
    .rst      (rst),
    .i_wdata  (len_wdata),
    .i_wvalid (len_wvalid),
    .o_wready (len_wready),
    .o_rdata  (o_len_tdata),
    .o_rvalid (o_len_tvalid),
    .i_rready (i_len_tready)
  );

  // Space was checked before the notice was taken, so the write always lands
  sync_fifo #(
    .WIDTH      ($bits(fft_depkt_pkg::cp_len_t)),
    .DEPTH_LOG2 (fft_depkt_pkg::CP_FIFO_DEPTH_LOG2)
  ) u_cp_fifo (
    .clk      (clk),
    .rst      (rst),
    .i_wdata  (cp_len),
    .i_wvalid (prefix_rd_stb),
    .o_wready (cp_wready),
    .o_rdata  (o_cp_ins_tdata),
    .o_rvalid (o_cp_ins_tvalid),
    .i_rready (i_cp_ins_tready_dn)
  );

endmodule

`default_nettype wire

/* packet_resizer/packet_resizer.sv */
// NoC packet resizer
`default_nettype none

module packet_resizer (
  input  wire                          clk,
  input  wire                          rst,
  input  wire fft_depkt_pkg::fft_log2_t i_fft_size_log2,
  input  wire fft_depkt_pkg::burst_info_t i_burst_tdata,
  input  wire                          i_burst_tvalid,
  output logic                         o_burst_tready,
  input  wire fft_depkt_pkg::symbol_len_t i_len_tdata,
  input  wire                          i_len_tvalid,
  output logic                         o_len_tready,
  input  wire fft_depkt_pkg::item_t    i_smp_tdata,
  input  wire                          i_smp_tvalid,
  output logic                         o_smp_tready,
  output fft_depkt_pkg::item_t         o_noc_tdata,
  output logic                         o_noc_tlast,
  output logic                         o_noc_tvalid,
  output fft_depkt_pkg::noc_side_t     o_noc_side,
  input  wire                          i_noc_tready
);

  typedef enum logic [2:0] {
    WAIT_BURST_ST,
    CALC_ITEMS_ST,
    CALC_PACKET_ST,
    CALC_VECTOR_ST,
    CALC_EOV_ST,
    PASS_PACKET_ST
  } state_t;

  state_t                     state;
  fft_depkt_pkg::fft_size_t   fft_mask;
  // Settings of the burst in progress
  fft_depkt_pkg::pkt_size_t   pkt_size;
  fft_depkt_pkg::timestamp_t  timestamp;
  logic                       has_time;
  logic                       last_symbol;
  fft_depkt_pkg::items_left_t items_left;
  // Packet being set up or sent
  fft_depkt_pkg::pkt_size_t   next_size;
  fft_depkt_pkg::pkt_size_t   pkt_item_count;
  fft_depkt_pkg::fft_size_t   vect_pos;
  fft_depkt_pkg::noc_side_t   side;
  logic                       xfer;

  // FFT sizes are powers of two, so the vector position is checked by mask
  always_ff @(posedge clk) begin
    fft_mask <= (fft_depkt_pkg::fft_size_t'(1) << i_fft_size_log2) - 1'b1;
  end

  assign xfer = o_noc_tvalid && i_noc_tready;

  // ----------------------------------------------------------------------
  // Packet FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= WAIT_BURST_ST;
      o_burst_tready <= 1'b0;
      o_len_tready   <= 1'b0;
    end else begin
      o_burst_tready <= 1'b0;
      o_len_tready   <= 1'b0;
      case (state)
        WAIT_BURST_ST: begin
          items_left     <= '0;
          vect_pos       <= '0;
          o_burst_tready <= 1'b1;
          if (i_burst_tvalid && o_burst_tready) begin
            o_burst_tready <= 1'b0;
            pkt_size       <= i_burst_tdata.pkt_size;
            timestamp      <= i_burst_tdata.timestamp;
            has_time       <= i_burst_tdata.has_time;
            o_len_tready   <= 1'b1;
            state          <= CALC_ITEMS_ST;
          end
        end
        CALC_ITEMS_ST: begin
          // Add one more symbol to what is still owed
          o_len_tready <= 1'b1;
          if (i_len_tvalid && o_len_tready) begin
            o_len_tready <= 1'b0;
            last_symbol  <= i_len_tdata.last;
            items_left   <= items_left + fft_depkt_pkg::items_left_t'(i_len_tdata.length);
            state        <= CALC_PACKET_ST;
          end
        end
        CALC_PACKET_ST: begin
          // Count starts at two to cover the registered tlast
          pkt_item_count <= fft_depkt_pkg::pkt_size_t'(2);
          side.timestamp <= timestamp;
          side.has_time  <= has_time;
          side.eob       <= 1'b0;
          next_size      <= pkt_size;
          if (items_left > fft_depkt_pkg::items_left_t'(pkt_size)) begin
            state <= CALC_VECTOR_ST;
          end else if (last_symbol) begin
            // Whatever remains closes the burst
            next_size <= fft_depkt_pkg::pkt_size_t'(items_left);
            side.eob  <= 1'b1;
            state     <= CALC_VECTOR_ST;
          end else if (items_left == fft_depkt_pkg::items_left_t'(pkt_size)) begin
            state <= CALC_VECTOR_ST;
          end else begin
            // Not enough for a packet yet, so fetch the next symbol
            o_len_tready <= 1'b1;
            state        <= CALC_ITEMS_ST;
          end
        end
        CALC_VECTOR_ST: begin
          vect_pos    <= vect_pos + fft_depkt_pkg::fft_size_t'(next_size);
          side.length <= fft_depkt_pkg::length_bytes_t'(next_size) *
                         fft_depkt_pkg::length_bytes_t'(fft_depkt_pkg::BYTES_PER_ITEM);
          state       <= CALC_EOV_ST;
        end
        CALC_EOV_ST: begin
          side.eov    <= (vect_pos & fft_mask) == '0;
          // A one-item packet ends on its first transfer
          o_noc_tlast <= next_size <= fft_depkt_pkg::pkt_size_t'(1);
          state       <= PASS_PACKET_ST;
        end
        PASS_PACKET_ST: begin
          if (xfer) begin
            timestamp      <= timestamp + 1'b1;
            items_left     <= items_left - 1'b1;
            pkt_item_count <= pkt_item_count + 1'b1;
            o_noc_tlast    <= pkt_item_count >= next_size;
            if (o_noc_tlast) begin
              state <= side.eob ? WAIT_BURST_ST : CALC_PACKET_ST;
            end
          end
        end
        default: begin
          state <= WAIT_BURST_ST;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Sample pass-through
  // ----------------------------------------------------------------------

  // Samples only move once the packet sideband is settled
  assign o_noc_tdata  = i_smp_tdata;
  assign o_noc_tvalid = (state == PASS_PACKET_ST) && i_smp_tvalid;
  assign o_smp_tready = (state == PASS_PACKET_ST) && i_noc_tready;
  assign o_noc_side   = side;

endmodule

`default_nettype wire

/* src/fft_depacketize.sv */
// FFT depacketizer top level
`default_nettype none

module fft_depacketize (
  input  wire                           clk,
  input  wire                           rst,
  // Static configuration, set before the first burst
  input  wire fft_depkt_pkg::fft_log2_t  i_fft_size_log2,
  // Burst settings
  input  wire fft_depkt_pkg::burst_info_t i_burst_tdata,
  input  wire                           i_burst_tvalid,
  output logic                          i_burst_tready,
  // Symbol notice, the data bit flags the last symbol of a burst
  input  wire                           i_symbol_tdata,
  input  wire                           i_symbol_tvalid,
  output logic                          i_symbol_tready,
  // Prefix length in and its copy out
  input  wire fft_depkt_pkg::cp_len_t    i_cp_ins_tdata,
  input  wire                           i_cp_ins_tvalid,
  output logic                          i_cp_ins_tready,
  output fft_depkt_pkg::cp_len_t        o_cp_ins_tdata,
  output logic                          o_cp_ins_tvalid,
  input  wire                           o_cp_ins_tready,
  // Samples from the FFT core
  input  wire fft_depkt_pkg::item_t      i_fft_tdata,
  input  wire                           i_fft_tvalid,
  output logic                          i_fft_tready,
  // Resized packets toward the NoC shell
  output fft_depkt_pkg::item_t          o_noc_tdata,
  output logic                          o_noc_tlast,
  output logic                          o_noc_tvalid,
  input  wire                           o_noc_tready,
  output fft_depkt_pkg::noc_side_t      o_noc_side
);

  fft_depkt_pkg::symbol_len_t len_tdata;
  logic                       len_tvalid;
  logic                       len_tready;
  fft_depkt_pkg::item_t       smp_tdata;
  logic                       smp_tvalid;
  logic                       smp_tready;

  // Symbol lengths and prefix copy
  symbol_sizer u_symbol_sizer (
    .clk                (clk),
    .rst                (rst),
    .i_fft_size_log2    (i_fft_size_log2),
    .i_symbol_tvalid    (i_symbol_tvalid),
    .i_symbol_last      (i_symbol_tdata),
    .o_symbol_tready    (i_symbol_tready),
    .i_cp_ins_tdata     (i_cp_ins_tdata),
    .i_cp_ins_tvalid    (i_cp_ins_tvalid),
    .o_cp_ins_rd        (i_cp_ins_tready),
    .o_cp_ins_tdata     (o_cp_ins_tdata),
    .o_cp_ins_tvalid    (o_cp_ins_tvalid),
    .i_cp_ins_tready_dn (o_cp_ins_tready),
    .o_len_tdata        (len_tdata),
    .o_len_tvalid       (len_tvalid),
    .i_len_tready       (len_tready)
  );

  // Buffers FFT output while the resizer sets up each packet
  sync_fifo #(
    .WIDTH      (fft_depkt_pkg::ITEM_W),
    .DEPTH_LOG2 (fft_depkt_pkg::DATA_FIFO_DEPTH_LOG2)
  ) u_sample_buf (
    .clk      (clk),
    .rst      (rst),
    .i_wdata  (i_fft_tdata),
    .i_wvalid (i_fft_tvalid),
    .o_wready (i_fft_tready),
    .o_rdata  (smp_tdata),
    .o_rvalid (smp_tvalid),
    .i_rready (smp_tready)
  );

  packet_resizer u_packet_resizer (
    .clk             (clk),
    .rst             (rst),
    .i_fft_size_log2 (i_fft_size_log2),
    .i_burst_tdata   (i_burst_tdata),
    .i_burst_tvalid  (i_burst_tvalid),
    .o_burst_tready  (i_burst_tready),
    .i_len_tdata     (len_tdata),
    .i_len_tvalid    (len_tvalid),
    .o_len_tready    (len_tready),
    .i_smp_tdata     (smp_tdata),
    .i_smp_tvalid    (smp_tvalid),
    .o_smp_tready    (smp_tready),
    .o_noc_tdata     (o_noc_tdata),
    .o_noc_tlast     (o_noc_tlast),
    .o_noc_tvalid    (o_noc_tvalid),
    .o_noc_side      (o_noc_side),
    .i_noc_tready    (o_noc_tready)
  );

endmodule

`default_nettype wire

/* verif/fft_depacketize_chk.sv */
// FFT depacketizer protocol checks
`default_nettype none

module fft_depacketize_chk (
  input wire                           clk,
  input wire                           rst,
  input wire                           i_burst_tready,
  input wire                           i_symbol_tready,
  input wire                           i_cp_ins_tready,
  input wire fft_depkt_pkg::cp_len_t   o_cp_ins_tdata,
  input wire                           o_cp_ins_tvalid,
  input wire                           o_cp_ins_tready,
  input wire fft_depkt_pkg::item_t     o_noc_tdata,
  input wire                           o_noc_tlast,
  input wire                           o_noc_tvalid,
  input wire                           o_noc_tready,
  input wire fft_depkt_pkg::noc_side_t o_noc_side
);

  // ----------------------------------------------------------------------
  // Stall behavior
  // ----------------------------------------------------------------------

  // A stalled NoC beat keeps its data, tlast and header fields
  noc_stall_hold: assert property (@(posedge clk) disable iff (rst)
    o_noc_tvalid && !o_noc_tready |=>
      o_noc_tvalid && $stable(o_noc_tdata) && $stable(o_noc_tlast) && $stable(o_noc_side))
    else $error("NoC beat changed while it was stalled");

  // The prefix copy waits the same way for its consumer
  cp_stall_hold: assert property (@(posedge clk) disable iff (rst)
    o_cp_ins_tvalid && !o_cp_ins_tready |=> o_cp_ins_tvalid && $stable(o_cp_ins_tdata))
    else $error("Prefix copy changed while it was stalled");

  // ----------------------------------------------------------------------
  // Reset and prefix read
  // ----------------------------------------------------------------------

  // Every handshake output is quiet in the cycle after a reset edge
  reset_quiet: assert property (@(posedge clk)
    rst |=> !o_noc_tvalid && !o_cp_ins_tvalid && !i_burst_tready &&
            !i_symbol_tready && !i_cp_ins_tready)
    else $error("Handshake output was high right after reset");

  // The prefix is read once per notice, so its ready never lasts two cycles
  cp_read_pulse: assert property (@(posedge clk) disable iff (rst)
    i_cp_ins_tready |=> !i_cp_ins_tready)
    else $error("Prefix ready stayed high for more than one cycle");

endmodule

bind fft_depacketize fft_depacketize_chk u_chk (
  .clk             (clk),
  .rst             (rst),
  .i_burst_tready  (i_burst_tready),
  .i_symbol_tready (i_symbol_tready),
  .i_cp_ins_tready (i_cp_ins_tready),
  .o_cp_ins_tdata  (o_cp_ins_tdata),
  .o_cp_ins_tvalid (o_cp_ins_tvalid),
  .o_cp_ins_tready (o_cp_ins_tready),
  .o_noc_tdata     (o_noc_tdata),
  .o_noc_tlast     (o_noc_tlast),
  .o_noc_tvalid    (o_noc_tvalid),
  .o_noc_tready    (o_noc_tready),
  .o_noc_side      (o_noc_side)
);

`default_nettype wire

/* verif/fft_depacketize_tb.sv */
// FFT depacketizer testbench
`default_nettype none

module fft_depacketize_tb;

  localparam int NUM_BURSTS = 8;
  localparam int FFT_LOG2   = 4;
  localparam int FFT_SIZE   = 1 << FFT_LOG2;
  localparam int TIMEOUT    = 3000;
  localparam int BYTES      = fft_depkt_pkg::BYTES_PER_ITEM;
  // Selects which ready signal a wait loop watches
  localparam int PORT_BURST  = 0;
  localparam int PORT_SYMBOL = 1;
  localparam int PORT_CP     = 2;
  localparam int PORT_FFT    = 3;

  logic                        clk             = 1'b0;
  logic                        rst             = 1'b1;
  fft_depkt_pkg::fft_log2_t    i_fft_size_log2 = 3'd4;
  fft_depkt_pkg::burst_info_t  i_burst_tdata   = '0;
  logic                        i_burst_tvalid  = 1'b0;
  logic                        i_burst_tready;
  logic                        i_symbol_tdata  = 1'b0;
  logic                        i_symbol_tvalid = 1'b0;
  logic                        i_symbol_tready;
  fft_depkt_pkg::cp_len_t      i_cp_ins_tdata  = '0;
  logic                        i_cp_ins_tvalid = 1'b0;
  logic                        i_cp_ins_tready;
  fft_depkt_pkg::cp_len_t      o_cp_ins_tdata;
  logic                        o_cp_ins_tvalid;
  logic                        o_cp_ins_tready = 1'b0;
  fft_depkt_pkg::item_t        i_fft_tdata     = '0;
  logic                        i_fft_tvalid    = 1'b0;
  logic                        i_fft_tready;
  fft_depkt_pkg::item_t        o_noc_tdata;
  logic                        o_noc_tlast;
  logic                        o_noc_tvalid;
  logic                        o_noc_tready    = 1'b0;
  fft_depkt_pkg::noc_side_t    o_noc_side;

  // Stimulus for every burst, drawn before the run starts
  fft_depkt_pkg::burst_info_t  bursts [NUM_BURSTS];
  fft_depkt_pkg::cp_len_t      cps [NUM_BURSTS][4];
  int                          sym_count [NUM_BURSTS];
  // Reference model output, consumed in order by the monitor
  fft_depkt_pkg::noc_side_t    exp_side_q [$];
  fft_depkt_pkg::cp_len_t      exp_cp_q [$];
  fft_depkt_pkg::noc_side_t    want;
  int                          total_samples = 0;
  int                          next_sample   = 0;
  int                          beat_count    = 0;
  int                          packets       = 0;
  int                          errors        = 0;
  int                          timeouts      = 0;

  fft_depacketize uut (.*);

  always #50 clk = ~clk;

  // Consumers stall at random, changing only on the falling edge
  always @(negedge clk) begin
    o_noc_tready    = ($urandom % 4) != 0;
    o_cp_ins_tready = ($urandom % 3) != 0;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected == actual) else begin
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  function automatic logic ready_of(input int port);
    case (port)
      PORT_BURST:  return i_burst_tready;
      PORT_SYMBOL: return i_symbol_tready;
      PORT_CP:     return i_cp_ins_tready;
      default:     return i_fft_tready;
    endcase
  endfunction

  // Returns at the rising edge where the selected ready is seen high
  task automatic await_ready(input int port, input string what, output bit ok);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!ready_of(port) && cycles < TIMEOUT);
    ok = ready_of(port);
    if (!ok) begin
      $display("Timeout: the DUT never accepted the %s", what);
      timeouts++;
    end
  endtask

  // Full packets while more than a packet remains, then the rest with EOB
  task automatic model_burst(input int b);
    int total;
    int sent;
    int size;
    int pkt;
    fft_depkt_pkg::noc_side_t side;
    total = 0;
    sent  = 0;
    pkt   = int'(bursts[b].pkt_size);
    for (int s = 0; s < sym_count[b]; s++) begin
      total += FFT_SIZE + int'(cps[b][s]);
      exp_cp_q.push_back(cps[b][s]);
    end
    total_samples += total;
    while (sent < total) begin
      size           = (total - sent > pkt) ? pkt : total - sent;
      side.length    = fft_depkt_pkg::length_bytes_t'(size * BYTES);
      side.timestamp = bursts[b].timestamp + 64'(sent);
      side.has_time  = bursts[b].has_time;
      sent          += size;
      side.eov       = (sent % FFT_SIZE) == 0;
      side.eob       = (sent == total);
      exp_side_q.push_back(side);
    end
  endtask

  // ----------------------------------------------------------------------
  // Drivers
  // ----------------------------------------------------------------------

  task automatic drive_controls();
    bit ok;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      i_burst_tdata  = bursts[b];
      i_burst_tvalid = 1'b1;
      await_ready(PORT_BURST, "burst info", ok);
      if (!ok) return;
      @(negedge clk);
      i_burst_tvalid = 1'b0;
      for (int s = 0; s < sym_count[b]; s++) begin
        // The prefix rides along with its notice until the read pulse
        i_symbol_tdata  = (s == sym_count[b] - 1);
        i_symbol_tvalid = 1'b1;
        i_cp_ins_tdata  = cps[b][s];
        i_cp_ins_tvalid = 1'b1;
        await_ready(PORT_SYMBOL, "symbol notice", ok);
        if (!ok) return;
        await_ready(PORT_CP, "prefix length", ok);
        if (!ok) return;
        @(negedge clk);
        i_symbol_tvalid = 1'b0;
        i_cp_ins_tvalid = 1'b0;
      end
    end
  endtask

  task automatic drive_samples();
    bit ok;
    for (int n = 0; n < total_samples; n++) begin
      if (($urandom % 4) == 0) begin
        i_fft_tvalid = 1'b0;
        @(negedge clk);
      end
      i_fft_tdata  = fft_depkt_pkg::item_t'(n);
      i_fft_tvalid = 1'b1;
      await_ready(PORT_FFT, "FFT sample", ok);
      if (!ok) return;
      @(negedge clk);
    end
    i_fft_tvalid = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Monitor
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst && o_noc_tvalid && o_noc_tready) begin
      check_value("sample data", 64'(next_sample), 64'(o_noc_tdata));
      next_sample++;
      beat_count++;
      if (exp_side_q.size() == 0) begin
        $display("A NoC beat arrived when no packet was expected");
        errors++;
      end else begin
        want = exp_side_q[0];
        check_value("tlast", 64'(beat_count == int'(want.length) / BYTES), 64'(o_noc_tlast));
        if (o_noc_tlast) begin
          check_value("packet length", 64'(want.length), 64'(o_noc_side.length));
          check_value("timestamp", want.timestamp, o_noc_side.timestamp);
          check_value("has time", 64'(want.has_time), 64'(o_noc_side.has_time));
          check_value("eov", 64'(want.eov), 64'(o_noc_side.eov));
          check_value("eob", 64'(want.eob), 64'(o_noc_side.eob));
          void'(exp_side_q.pop_front());
          beat_count = 0;
          packets++;
        end
      end
    end
    if (!rst && o_cp_ins_tvalid && o_cp_ins_tready) begin
      if (exp_cp_q.size() == 0) begin
        $display("A prefix copy arrived when none was expected");
        errors++;
      end else begin
        check_value("prefix copy", 64'(exp_cp_q[0]), 64'(o_cp_ins_tdata));
        void'(exp_cp_q.pop_front());
      end
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int cycles;
    void'($urandom(32'h8e7b));
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      bursts[b].pkt_size  = fft_depkt_pkg::pkt_size_t'(8 + $urandom % 249);
      bursts[b].timestamp = {$urandom, $urandom};
      bursts[b].has_time  = 1'($urandom % 2);
      sym_count[b]        = 1 + int'($urandom % 4);
      for (int s = 0; s < 4; s++) begin
        cps[b][s] = fft_depkt_pkg::cp_len_t'($urandom % 64);
      end
      model_burst(b);
    end
    fork
      drive_controls();
      drive_samples();
    join
    // Let the last packets and prefix copies drain
    cycles = 0;
    while ((exp_side_q.size() != 0 || exp_cp_q.size() != 0) && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_side_q.size() != 0 || exp_cp_q.size() != 0) begin
      $display("Timeout: %0d packets and %0d prefix copies never came out",
               exp_side_q.size(), exp_cp_q.size());
      timeouts++;
    end
    $display("Checked %0d packets and %0d samples: %0d errors, %0d timeouts",
             packets, next_sample, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
common/fft_depkt_pkg.sv
src/sync_fifo.sv
symbol_sizer/symbol_sizer.sv
packet_resizer/packet_resizer.sv
src/fft_depacketize.sv
verif/fft_depacketize_chk.sv
verif/fft_depacketize_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the FFT depacketizer testbench with Verilator
set -euo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module fft_depacketize_tb \
  -f compile.f \
  -o fft_depacketize_sim

./obj_dir/fft_depacketize_sim 2>&1 | tee sim.log

if grep -qxF "** PASS **" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
